// ==== hw/rv_core_pkg.sv ====
// Shared RV32I types and encodings, imported by the core RTL and the testbench
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [1:0]  src_sel_t;
  typedef logic [2:0]  funct3_t;

  // Operand sources
  localparam src_sel_t SRC_RF   = 2'd0;
  localparam src_sel_t SRC_IMM  = 2'd1;
  localparam src_sel_t SRC_ZERO = 2'd2;
  localparam src_sel_t SRC_PC   = 2'd3;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // ALU function codes
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // Branch conditions
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

endpackage

// ==== hw/decode.sv ====
// Decode stage register, turns an accepted instruction word into execute control fields
`timescale 1ns/1ps
module decode (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  instr_valid_i,
  input  rv_core_pkg::word_t    instr_i,
  input  rv_core_pkg::word_t    instr_pc_i,
  input  logic                  id_ready_i,
  input  logic                  flush_i,
  output logic                  dec_valid_o,
  output rv_core_pkg::word_t    dec_pc_o,
  output rv_core_pkg::word_t    dec_imm_o,
  output rv_core_pkg::reg_addr_t dec_rd_o,
  output rv_core_pkg::reg_addr_t dec_rs1_o,
  output rv_core_pkg::reg_addr_t dec_rs2_o,
  output rv_core_pkg::src_sel_t dec_src1_sel_o,
  output rv_core_pkg::src_sel_t dec_src2_sel_o,
  output rv_core_pkg::funct3_t  dec_f3_o,
  output logic                  dec_alt_o,
  output logic                  dec_we_o,
  output logic                  dec_branch_o,
  output logic                  dec_jump_o
);
  import rv_core_pkg::*;

  logic [6:0] opcode;
  funct3_t    f3;
  word_t      imm_i, imm_u, imm_b, imm_j;
  word_t      imm;
  src_sel_t   src1_sel, src2_sel;
  funct3_t    alu_f3;
  logic       alt, known, we, branch, jump;

  assign opcode = instr_i[6:0];
  assign f3     = instr_i[14:12];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    imm      = imm_i;
    src1_sel = SRC_RF;
    src2_sel = SRC_IMM;
    alu_f3   = F3_ADD_SUB;
    alt      = 1'b0;
    known    = 1'b1;
    we       = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    case (opcode)
      OPC_OP: begin
        src2_sel = SRC_RF;
        alu_f3   = f3;
        alt      = instr_i[30];
        we       = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_f3 = f3;
        // Only shifts carry the arithmetic bit
        alt    = (f3 == F3_SRL_SRA) && instr_i[30];
        we     = 1'b1;
      end
      OPC_LUI: begin
        imm      = imm_u;
        src1_sel = SRC_ZERO;
        we       = 1'b1;
      end
      OPC_AUIPC: begin
        imm      = imm_u;
        src1_sel = SRC_PC;
        we       = 1'b1;
      end
      OPC_JAL: begin
        imm      = imm_j;
        src1_sel = SRC_PC;
        we       = 1'b1;
        jump     = 1'b1;
      end
      OPC_JALR: begin
        we   = 1'b1;
        jump = 1'b1;
      end
      OPC_BRANCH: begin
        imm      = imm_b;
        src2_sel = SRC_RF;
        alu_f3   = f3;
        branch   = 1'b1;
      end
      default: known = 1'b0;
    endcase
  end

  // Control fields load a bubble on flush
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_o  <= 1'b0;
      dec_we_o     <= 1'b0;
      dec_branch_o <= 1'b0;
      dec_jump_o   <= 1'b0;
    end else if (flush_i) begin
      dec_valid_o  <= 1'b0;
      dec_we_o     <= 1'b0;
      dec_branch_o <= 1'b0;
      dec_jump_o   <= 1'b0;
    end else if (id_ready_i) begin
      dec_valid_o  <= instr_valid_i && known;
      dec_we_o     <= instr_valid_i && known && we;
      dec_branch_o <= instr_valid_i && branch;
      dec_jump_o   <= instr_valid_i && jump;
    end
  end

  always_ff @(posedge clk) begin
    if (id_ready_i) begin
      dec_pc_o       <= instr_pc_i;
      dec_imm_o      <= imm;
      dec_rd_o       <= instr_i[11:7];
      dec_rs1_o      <= instr_i[19:15];
      dec_rs2_o      <= instr_i[24:20];
      dec_src1_sel_o <= src1_sel;
      dec_src2_sel_o <= src2_sel;
      dec_f3_o       <= alu_f3;
      dec_alt_o      <= alt;
    end
  end

endmodule

// ==== hw/regfile.sv ====
// Integer register file, two combinational reads and one write per cycle
`timescale 1ns/1ps
module regfile (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  rv_core_pkg::reg_addr_t rs1_addr_i,
  input  rv_core_pkg::reg_addr_t rs2_addr_i,
  output rv_core_pkg::word_t     rs1_data_o,
  output rv_core_pkg::word_t     rs2_data_o,
  input  logic                   we_i,
  input  rv_core_pkg::reg_addr_t waddr_i,
  input  rv_core_pkg::word_t     wdata_i
);
  import rv_core_pkg::*;

  word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 is hardwired
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== hw/execute.sv ====
// Execute stage with forwarding, ALU, branch resolution and the writeback register
`timescale 1ns/1ps
module execute (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   dec_valid_i,
  input  rv_core_pkg::word_t     dec_pc_i,
  input  rv_core_pkg::word_t     dec_imm_i,
  input  rv_core_pkg::reg_addr_t dec_rd_i,
  input  rv_core_pkg::reg_addr_t dec_rs1_i,
  input  rv_core_pkg::reg_addr_t dec_rs2_i,
  input  rv_core_pkg::src_sel_t  dec_src1_sel_i,
  input  rv_core_pkg::src_sel_t  dec_src2_sel_i,
  input  rv_core_pkg::funct3_t   dec_f3_i,
  input  logic                   dec_alt_i,
  input  logic                   dec_we_i,
  input  logic                   dec_branch_i,
  input  logic                   dec_jump_i,
  input  rv_core_pkg::word_t     rs1_data_i,
  input  rv_core_pkg::word_t     rs2_data_i,
  input  logic                   stall_i,
  output logic                   id_ready_o,
  output logic                   fetch_req_o,
  output rv_core_pkg::word_t     fetch_addr_o,
  output logic                   wb_valid_o,
  output rv_core_pkg::word_t     wb_pc_o,
  output logic                   wb_we_o,
  output rv_core_pkg::reg_addr_t wb_rd_o,
  output rv_core_pkg::word_t     wb_data_o
);
  import rv_core_pkg::*;

  word_t op1, op2, res;
  logic  fwd1, fwd2;
  logic  take_branch;
  logic  redir_d;
  word_t target_d;

  function automatic logic branch_taken(funct3_t cond, word_t a, word_t b);
    case (cond)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      F3_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t src_mux(src_sel_t sel, word_t rf, word_t imm, word_t pc);
    case (sel)
      SRC_RF:  return rf;
      SRC_IMM: return imm;
      SRC_PC:  return pc;
      default: return '0;
    endcase
  endfunction

  // Writeback we is already squash-gated
  assign fwd1 = wb_we_o && (wb_rd_o != '0) && (dec_src1_sel_i == SRC_RF) &&
                (dec_rs1_i == wb_rd_o);
  assign fwd2 = wb_we_o && (wb_rd_o != '0) && (dec_src2_sel_i == SRC_RF) &&
                (dec_rs2_i == wb_rd_o);

  assign op1 = fwd1 ? wb_data_o : src_mux(dec_src1_sel_i, rs1_data_i, dec_imm_i, dec_pc_i);
  assign op2 = fwd2 ? wb_data_o : src_mux(dec_src2_sel_i, rs2_data_i, dec_imm_i, dec_pc_i);

  always_comb begin
    case (dec_f3_i)
      F3_ADD_SUB: res = dec_alt_i ? op1 - op2 : op1 + op2;
      F3_SLL:     res = op1 << op2[4:0];
      F3_SLT:     res = word_t'($signed(op1) < $signed(op2));
      F3_SLTU:    res = word_t'(op1 < op2);
      F3_XOR:     res = op1 ^ op2;
      F3_SRL_SRA: res = dec_alt_i ? word_t'($signed(op1) >>> op2[4:0]) : op1 >> op2[4:0];
      F3_OR:      res = op1 | op2;
      default:    res = op1 & op2;
    endcase
  end

  assign take_branch = branch_taken(dec_f3_i, op1, op2);
  assign id_ready_o  = !stall_i;

  // The instruction right behind a redirect may not redirect itself
  assign redir_d  = dec_valid_i && !stall_i && !fetch_req_o &&
                    (dec_jump_i || (dec_branch_i && take_branch));
  assign target_d = dec_jump_i ? {res[31:1], 1'b0} : dec_pc_i + dec_imm_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_req_o <= 1'b0;
      wb_valid_o  <= 1'b0;
      wb_we_o     <= 1'b0;
    end else begin
      fetch_req_o <= redir_d;
      wb_valid_o  <= dec_valid_i && !stall_i;
      wb_we_o     <= dec_we_i && dec_valid_i && !stall_i && !fetch_req_o;
    end
  end

  always_ff @(posedge clk) begin
    fetch_addr_o <= target_d;
    wb_pc_o      <= dec_pc_i;
    wb_rd_o      <= dec_rd_i;
    wb_data_o    <= dec_jump_i ? dec_pc_i + 32'd4 : res;
  end

endmodule

// ==== hw/rv_core_top.sv ====
// Core top level, joins decode, register file and execute behind the fetch and retire ports
`timescale 1ns/1ps
module rv_core_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   instr_valid_i,
  input  rv_core_pkg::word_t     instr_i,
  input  rv_core_pkg::word_t     instr_pc_i,
  input  logic                   stall_i,
  output logic                   fetch_req_o,
  output rv_core_pkg::word_t     fetch_addr_o,
  output logic                   retire_valid_o,
  output rv_core_pkg::word_t     retire_pc_o,
  output logic                   rd_we_o,
  output rv_core_pkg::reg_addr_t rd_addr_o,
  output rv_core_pkg::word_t     rd_data_o
);
  import rv_core_pkg::*;

  logic      dec_valid, dec_alt, dec_we, dec_branch, dec_jump;
  word_t     dec_pc, dec_imm;
  reg_addr_t dec_rd, dec_rs1, dec_rs2;
  src_sel_t  dec_src1_sel, dec_src2_sel;
  funct3_t   dec_f3;
  word_t     rs1_data, rs2_data;
  logic      id_ready;
  logic      flush;

  assign flush = fetch_req_o;

  decode i_decode (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_pc_i     (instr_pc_i),
    .id_ready_i     (id_ready),
    .flush_i        (flush),
    .dec_valid_o    (dec_valid),
    .dec_pc_o       (dec_pc),
    .dec_imm_o      (dec_imm),
    .dec_rd_o       (dec_rd),
    .dec_rs1_o      (dec_rs1),
    .dec_rs2_o      (dec_rs2),
    .dec_src1_sel_o (dec_src1_sel),
    .dec_src2_sel_o (dec_src2_sel),
    .dec_f3_o       (dec_f3),
    .dec_alt_o      (dec_alt),
    .dec_we_o       (dec_we),
    .dec_branch_o   (dec_branch),
    .dec_jump_o     (dec_jump)
  );

  // Writes come from the retire register
  regfile i_regfile (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (dec_rs1),
    .rs2_addr_i (dec_rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (rd_we_o),
    .waddr_i    (rd_addr_o),
    .wdata_i    (rd_data_o)
  );

  execute i_execute (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .dec_valid_i    (dec_valid),
    .dec_pc_i       (dec_pc),
    .dec_imm_i      (dec_imm),
    .dec_rd_i       (dec_rd),
    .dec_rs1_i      (dec_rs1),
    .dec_rs2_i      (dec_rs2),
    .dec_src1_sel_i (dec_src1_sel),
    .dec_src2_sel_i (dec_src2_sel),
    .dec_f3_i       (dec_f3),
    .dec_alt_i      (dec_alt),
    .dec_we_i       (dec_we),
    .dec_branch_i   (dec_branch),
    .dec_jump_i     (dec_jump),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .stall_i        (stall_i),
    .id_ready_o     (id_ready),
    .fetch_req_o    (fetch_req_o),
    .fetch_addr_o   (fetch_addr_o),
    .wb_valid_o     (retire_valid_o),
    .wb_pc_o        (retire_pc_o),
    .wb_we_o        (rd_we_o),
    .wb_rd_o        (rd_addr_o),
    .wb_data_o      (rd_data_o)
  );

endmodule

// ==== dv/rv_core_chk.sv ====
// Concurrent checks on execute redirect, stall and reset behavior, bound into execute
`timescale 1ns/1ps
module rv_core_chk (
  input logic clk,
  input logic rst_n_i,
  input logic stall_i,
  input logic fetch_req_i,
  input logic wb_valid_i,
  input logic wb_we_i
);

  // Redirect is a single-cycle strobe
  redirect_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n_i) fetch_req_i |=> !fetch_req_i
  ) else $error("fetch_req_o high in two consecutive cycles");

  stall_blocks_retire: assert property (
    @(posedge clk) disable iff (!rst_n_i) stall_i |=> !wb_valid_i
  ) else $error("retire_valid_o high in the cycle after stall_i");

  reset_quiet: assert property (
    @(posedge clk) !rst_n_i |-> !fetch_req_i && !wb_valid_i && !wb_we_i
  ) else $error("fetch_req_o, retire_valid_o or rd_we_o active during reset");

endmodule

// ==== dv/rv_core_tb.sv ====
// Self-checking testbench for rv_core_top, random RV32I program checked against an ISA model
`timescale 1ns/1ps
module rv_core_tb;
  import rv_core_pkg::*;

  localparam int NUM_RETIRES = 2000;
  localparam int MEM_WORDS   = 64;
  localparam int WATCHDOG_NS = (NUM_RETIRES * 4 + 100) * 8;

  logic      clk = 1'b0;
  logic      rst_n_i;
  logic      instr_valid_i;
  word_t     instr_i;
  word_t     instr_pc_i;
  logic      stall_i;
  logic      fetch_req_o;
  word_t     fetch_addr_o;
  logic      retire_valid_o;
  word_t     retire_pc_o;
  logic      rd_we_o;
  reg_addr_t rd_addr_o;
  word_t     rd_data_o;

  word_t  imem [0:MEM_WORDS-1];
  word_t  xreg [0:31];
  word_t  model_pc;
  word_t  fetch_pc;
  integer seed;
  int     retired;

  rv_core_top i_rv_core_top (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .instr_pc_i     (instr_pc_i),
    .stall_i        (stall_i),
    .fetch_req_o    (fetch_req_o),
    .fetch_addr_o   (fetch_addr_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .rd_we_o        (rd_we_o),
    .rd_addr_o      (rd_addr_o),
    .rd_data_o      (rd_data_o)
  );

  bind execute rv_core_chk i_rv_core_chk (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall_i),
    .fetch_req_i (fetch_req_o),
    .wb_valid_i  (wb_valid_o),
    .wb_we_i     (wb_we_o)
  );

  always #4 clk = ~clk;

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Fail %s expected %08h actual %08h", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (exp !== act) begin
      $display("Fail %s expected x%0d actual x%0d", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Fail %s expected %b actual %b", name, exp, act);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // Registers limited to x0..x7 so neighbours often depend on each other
  function automatic word_t gen_instr(int idx);
    word_t       rnd;
    int          kind;
    int          tgt;
    reg_addr_t   rd, rs1, rs2;
    funct3_t     f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [12:0] boff;
    logic [20:0] joff;
    rnd   = $random(seed);
    kind  = rand_below(100);
    tgt   = rand_below(MEM_WORDS);
    rd    = reg_addr_t'(rand_below(8));
    rs1   = reg_addr_t'(rand_below(8));
    rs2   = reg_addr_t'(rand_below(8));
    f3    = funct3_t'(rand_below(8));
    f7    = (rand_below(2) == 1) ? 7'h20 : 7'h00;
    imm12 = rnd[11:0];
    boff  = 13'((tgt - idx) * 4);
    joff  = 21'((tgt - idx) * 4);
    if (kind < 30) begin
      if (f3 != F3_ADD_SUB && f3 != F3_SRL_SRA) f7 = 7'h00;
      return {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 60) begin
      if (f3 == F3_SLL) imm12[11:5] = 7'h00;
      if (f3 == F3_SRL_SRA) imm12[11:5] = f7;
      return {imm12, rs1, f3, rd, OPC_OP_IMM};
    end else if (kind < 68) begin
      return {rnd[31:12], rd, OPC_LUI};
    end else if (kind < 76) begin
      return {rnd[31:12], rd, OPC_AUIPC};
    end else if (kind < 82) begin
      return {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
    end else if (kind < 86) begin
      return {12'(tgt * 4), 5'd0, 3'b000, rd, OPC_JALR};
    end
    // Funct3 010 and 011 map onto BLTU and BGEU
    if (f3[2:1] == 2'b01) f3[2] = 1'b1;
    return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
  endfunction

  function automatic word_t alu_result(funct3_t f3, logic alt, word_t a, word_t b);
    case (f3)
      F3_ADD_SUB: return alt ? a - b : a + b;
      F3_SLL:     return a << b[4:0];
      F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:     return a ^ b;
      F3_SRL_SRA: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      F3_OR:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  // Bit 0 of funct3 inverts the condition
  function automatic logic branch_cond(funct3_t f3, word_t a, word_t b);
    logic c;
    case (f3[2:1])
      2'b00:   c = (a == b);
      2'b10:   c = $signed(a) < $signed(b);
      default: c = (a < b);
    endcase
    return c ^ f3[0];
  endfunction

  task automatic step_model(output logic we, output reg_addr_t rd, output word_t data,
                            output logic taken, output word_t target);
    word_t w, a, b, imm_i, imm_u, imm_b, imm_j;
    w     = imem[model_pc[7:2]];
    a     = xreg[w[19:15]];
    b     = xreg[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'h000};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    we     = 1'b1;
    rd     = w[11:7];
    taken  = 1'b0;
    target = '0;
    case (w[6:0])
      OPC_OP:     data = alu_result(w[14:12], w[30], a, b);
      OPC_OP_IMM: data = alu_result(w[14:12], (w[14:12] == F3_SRL_SRA) && w[30], a, imm_i);
      OPC_LUI:    data = imm_u;
      OPC_AUIPC:  data = model_pc + imm_u;
      OPC_JAL: begin
        data   = model_pc + 32'd4;
        taken  = 1'b1;
        target = model_pc + imm_j;
      end
      OPC_JALR: begin
        data   = model_pc + 32'd4;
        taken  = 1'b1;
        target = (a + imm_i) & ~32'd1;
      end
      default: begin
        we     = 1'b0;
        data   = '0;
        taken  = branch_cond(w[14:12], a, b);
        target = model_pc + imm_b;
      end
    endcase
  endtask

  task automatic drive_fetch();
    stall_i       = (rand_below(8) == 0);
    instr_valid_i = 1'b1;
    instr_pc_i    = fetch_pc;
    instr_i       = imem[fetch_pc[7:2]];
  endtask

  initial begin
    logic      last_req, squash_armed, squash_pending;
    word_t     last_addr, squash_pc;
    logic      exp_we, exp_taken;
    reg_addr_t exp_rd;
    word_t     exp_data, exp_target;
    seed          = 97705;
    rst_n_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    instr_pc_i    = '0;
    stall_i       = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) imem[i] = gen_instr(i);
    for (int i = 0; i < 32; i++) xreg[i] = '0;
    model_pc       = '0;
    fetch_pc       = '0;
    retired        = 0;
    last_req       = 1'b0;
    last_addr      = '0;
    squash_armed   = 1'b0;
    squash_pending = 1'b0;
    squash_pc      = '0;
    #1 rst_n_i = 1'b0;
    repeat (2) @(posedge clk);
    #1 rst_n_i = 1'b1;
    drive_fetch();
    while (retired < NUM_RETIRES) begin
      @(posedge clk);
      #1;
      // Redirect takes priority over acceptance
      if (last_req) fetch_pc = last_addr;
      else if (!stall_i) fetch_pc = fetch_pc + 32'd4;
      last_req  = fetch_req_o;
      last_addr = fetch_addr_o;
      if (squash_pending) begin
        check_bit("squashed retire_valid_o", 1'b1, retire_valid_o);
        check_word("squashed retire_pc_o", squash_pc, retire_pc_o);
        check_bit("squashed rd_we_o", 1'b0, rd_we_o);
        check_bit("fetch_req_o after squash", 1'b0, fetch_req_o);
        squash_pending = 1'b0;
      end else if (retire_valid_o) begin
        check_word("retire_pc_o", model_pc, retire_pc_o);
        step_model(exp_we, exp_rd, exp_data, exp_taken, exp_target);
        check_bit($sformatf("rd_we_o pc %08h", model_pc), exp_we, rd_we_o);
        if (exp_we) begin
          check_reg($sformatf("rd_addr_o pc %08h", model_pc), exp_rd, rd_addr_o);
          check_word($sformatf("rd_data_o pc %08h", model_pc), exp_data, rd_data_o);
          if (exp_rd != '0) xreg[exp_rd] = exp_data;
        end
        check_bit($sformatf("fetch_req_o pc %08h", model_pc), exp_taken, fetch_req_o);
        if (exp_taken) begin
          check_word($sformatf("fetch_addr_o pc %08h", model_pc), exp_target, fetch_addr_o);
          squash_armed = 1'b1;
          squash_pc    = model_pc + 32'd4;
          model_pc     = exp_target;
        end else begin
          model_pc = model_pc + 32'd4;
        end
        retired++;
      end else begin
        check_bit("fetch_req_o without retire", 1'b0, fetch_req_o);
      end
      drive_fetch();
      // Younger instruction only retires if this redirect cycle is not stalled
      if (squash_armed) begin
        squash_pending = !stall_i;
        squash_armed   = 1'b0;
      end
    end
    $display("Verification passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, retires stopped at %0d of %0d", retired, NUM_RETIRES);
    $display("Verification failed");
    $fatal(1);
  end

endmodule

// ==== files.f ====
hw/rv_core_pkg.sv
hw/decode.sv
hw/regfile.sv
hw/execute.sv
hw/rv_core_top.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Verification passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulator printed the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
